// ==== dispatch_defs.svh ====
`ifndef DISPATCH_DEFS_SVH
`define DISPATCH_DEFS_SVH

// datapath widths and register file sizes
`define WORD_W      32
`define S_REGS      32
`define M_REGS      16

// scalar opcodes, standard RISC-V major opcode positions
`define OP_ALU      7'b0110011
`define OP_ALU_IMM  7'b0010011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_BRANCH   7'b1100011

// matrix extension, custom opcode space
`define OP_M_LOAD   7'b0000111
`define OP_M_STORE  7'b0100111
`define OP_GEMM     7'b1110111

// register status tags, zero means the value is ready
`define TAG_ALU     2'd1    // result from ALU or GEMM
`define TAG_LD      2'd2    // result from a load

`endif

// ==== dispatch_pkg.sv ====
`include "dispatch_defs.svh"

package dispatch_pkg;

    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [4:0]         sreg_t;     // scalar register index
    typedef logic [3:0]         mreg_t;     // matrix register index
    typedef logic [1:0]         tag_t;
    typedef logic [11:0]        imm_t;
    typedef logic [3:0]         alu_op_t;   // {funct7[5], funct3}
    typedef logic [2:0]         branch_op_t;

    typedef enum logic [1:0] {FU_NONE, FU_S_T, FU_M_T, FU_G_T} fu_type_e;
    typedef enum logic [1:0] {FU_S_ALU, FU_S_LD_ST, FU_S_BRANCH} fu_s_e;
    typedef enum logic       {FU_M_LD_ST, FU_M_GEMM} fu_m_e;
    typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_type_e;

    typedef struct packed {
        fu_type_e   fu_type;
        fu_s_e      fu_s;
        fu_m_e      fu_m;
        sreg_t      s_rd;
        sreg_t      s_rs1;
        sreg_t      s_rs2;
        mreg_t      m_rd;
        mreg_t      m_rs1;
        mreg_t      m_rs2;
        mreg_t      m_rs3;
        imm_t       imm;
        alu_op_t    alu_op;
        branch_op_t branch_op;
        mem_type_e  s_mem_type;
        mem_type_e  m_mem_type;
        logic       s_reg_write;
        logic       m_reg_write;
    } decode_t;

    typedef struct packed {
        logic busy;
        tag_t tag;
    } rst_entry_t;

    typedef struct packed {
        logic  s_rw_en;
        sreg_t s_rw;
        logic  m_rw_en;
        mreg_t m_rw;
    } wb_t;

    typedef struct packed {
        fu_s_e fu_s;
        sreg_t rd;
        sreg_t rs1;
        sreg_t rs2;
        imm_t  imm;
        tag_t  t1;
        tag_t  t2;
    } issue_s_t;

    // matrix load/store addresses through scalar registers
    typedef struct packed {
        mreg_t rd;
        sreg_t rs1;
        sreg_t rs2;
        imm_t  imm;
        tag_t  t1;
        tag_t  t2;
    } issue_m_t;

    typedef struct packed {
        mreg_t rd;
        mreg_t ms1;
        mreg_t ms2;
        mreg_t ms3;
        tag_t  t1;
        tag_t  t2;
        tag_t  t3;
    } issue_g_t;

    typedef struct packed {
        fu_s_e      fu_s;
        fu_m_e      fu_m;
        alu_op_t    alu_op;
        branch_op_t branch_op;
        imm_t       imm;
        mem_type_e  s_mem_type;
        mem_type_e  m_mem_type;
        wb_t        wb;
    } dispatch_t;

    typedef struct packed {
        logic alu;
        logic ldst;
        logic branch;
        logic m_ldst;
        logic gemm;
    } fu_done_t;

endpackage

// ==== instr_decoder.sv ====
`include "dispatch_defs.svh"

module instr_decoder (
    input  dispatch_pkg::word_t   instr,
    output dispatch_pkg::decode_t decode
);

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    always_comb begin
        decode = '0;

        // register fields are sliced unconditionally
        decode.s_rd  = instr[11:7];
        decode.s_rs1 = instr[19:15];
        decode.s_rs2 = instr[24:20];
        decode.m_rd  = instr[31:28];
        decode.m_rs1 = instr[27:24];
        decode.m_rs2 = instr[23:20];
        decode.m_rs3 = instr[19:16];

        case (opcode)
            `OP_ALU: begin
                decode.fu_type     = dispatch_pkg::FU_S_T;
                decode.fu_s        = dispatch_pkg::FU_S_ALU;
                decode.alu_op      = {instr[30], funct3};
                decode.s_reg_write = 1'b1;
            end
            `OP_ALU_IMM: begin
                decode.fu_type     = dispatch_pkg::FU_S_T;
                decode.fu_s        = dispatch_pkg::FU_S_ALU;
                decode.alu_op      = {instr[30] & (funct3 == 3'b101), funct3}; // srai only
                decode.imm         = instr[31:20];
                decode.s_reg_write = 1'b1;
            end
            `OP_LOAD: begin
                decode.fu_type     = dispatch_pkg::FU_S_T;
                decode.fu_s        = dispatch_pkg::FU_S_LD_ST;
                decode.imm         = instr[31:20];
                decode.s_mem_type  = dispatch_pkg::MEM_LOAD;
                decode.s_reg_write = 1'b1;
            end
            `OP_STORE: begin
                decode.fu_type    = dispatch_pkg::FU_S_T;
                decode.fu_s       = dispatch_pkg::FU_S_LD_ST;
                decode.imm        = {instr[31:25], instr[11:7]};
                decode.s_mem_type = dispatch_pkg::MEM_STORE;
            end
            `OP_BRANCH: begin
                decode.fu_type   = dispatch_pkg::FU_S_T;
                decode.fu_s      = dispatch_pkg::FU_S_BRANCH;
                decode.branch_op = funct3;
                decode.imm       = {instr[31], instr[7], instr[30:25], instr[11:8]}; // halfwords
            end
            `OP_M_LOAD: begin
                decode.fu_type     = dispatch_pkg::FU_M_T;
                decode.fu_m        = dispatch_pkg::FU_M_LD_ST;
                decode.imm         = {{4{instr[14]}}, instr[14:7]}; // short signed offset
                decode.m_mem_type  = dispatch_pkg::MEM_LOAD;
                decode.m_reg_write = 1'b1;
            end
            `OP_M_STORE: begin
                decode.fu_type    = dispatch_pkg::FU_M_T;
                decode.fu_m       = dispatch_pkg::FU_M_LD_ST;
                decode.imm        = {{4{instr[14]}}, instr[14:7]};
                decode.m_mem_type = dispatch_pkg::MEM_STORE;
            end
            `OP_GEMM: begin
                decode.fu_type     = dispatch_pkg::FU_G_T;
                decode.fu_m        = dispatch_pkg::FU_M_GEMM;
                decode.m_reg_write = 1'b1;
            end
            default: ; // unknown opcode, no unit
        endcase

        if (decode.s_rd == '0)
            decode.s_reg_write = 1'b0; // x0 never gets a pending result
    end

endmodule

// ==== reg_status_table.sv ====
module reg_status_table #(
    parameter  int NREGS = 32,
    localparam int SEL_W = $clog2(NREGS)
) (
    input  logic                                 CLK,
    input  logic                                 nRST,
    // dispatch side
    input  logic                                 set_en,
    input  logic [SEL_W-1:0]                     set_sel,
    input  dispatch_pkg::tag_t                   set_tag,
    // writeback side
    input  logic                                 clr_en,
    input  logic [SEL_W-1:0]                     clr_sel,
    output dispatch_pkg::rst_entry_t [NREGS-1:0] status
);

    dispatch_pkg::rst_entry_t [NREGS-1:0] status_next;

    always_comb begin
        status_next = status;

        // a register is never set while busy nor cleared while free,
        // so set and clear cannot meet on the same entry
        if (clr_en) begin
            status_next[clr_sel].busy = 1'b0;
            status_next[clr_sel].tag  = '0;
        end
        if (set_en) begin
            status_next[set_sel].busy = 1'b1;
            status_next[set_sel].tag  = set_tag;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            status <= '0;
        end else begin
            status <= status_next;
        end
    end

endmodule

// ==== fu_status_table.sv ====
module fu_status_table (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   issue_s_en,
    input  dispatch_pkg::fu_s_e    issue_s_fu,  // which scalar unit takes the issue
    input  logic                   issue_m_en,
    input  logic                   issue_g_en,
    input  dispatch_pkg::fu_done_t fu_done,
    output dispatch_pkg::fu_done_t busy
);

    dispatch_pkg::fu_done_t set_v;
    dispatch_pkg::fu_done_t busy_next;

    // one-hot set vector from the issue strobes
    always_comb begin
        set_v = '0;
        if (issue_s_en) begin
            case (issue_s_fu)
                dispatch_pkg::FU_S_ALU:    set_v.alu    = 1'b1;
                dispatch_pkg::FU_S_LD_ST:  set_v.ldst   = 1'b1;
                dispatch_pkg::FU_S_BRANCH: set_v.branch = 1'b1;
                default: ;
            endcase
        end
        set_v.m_ldst = issue_m_en;
        set_v.gemm   = issue_g_en;
    end

    // completion only hits busy units and issue only free ones
    always_comb begin
        busy_next        = busy;
        busy_next.alu    = (busy.alu    & ~fu_done.alu)    | set_v.alu;
        busy_next.ldst   = (busy.ldst   & ~fu_done.ldst)   | set_v.ldst;
        busy_next.branch = (busy.branch & ~fu_done.branch) | set_v.branch;
        busy_next.m_ldst = (busy.m_ldst & ~fu_done.m_ldst) | set_v.m_ldst;
        busy_next.gemm   = (busy.gemm   & ~fu_done.gemm)   | set_v.gemm;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy <= '0;
        end else begin
            busy <= busy_next;
        end
    end

endmodule

// ==== dispatch_stage.sv ====
`include "dispatch_defs.svh"

module dispatch_stage (
    input  logic                                    CLK,
    input  logic                                    nRST,
    input  logic                                    instr_valid,
    input  logic                                    flush,
    input  logic                                    freeze,
    input  dispatch_pkg::decode_t                   decode,
    input  dispatch_pkg::wb_t                       wb,
    input  dispatch_pkg::rst_entry_t [`S_REGS-1:0]  s_status,
    input  dispatch_pkg::rst_entry_t [`M_REGS-1:0]  m_status,
    input  dispatch_pkg::fu_done_t                  fu_busy,
    // register status table ports
    output logic                                    s_set_en,
    output dispatch_pkg::sreg_t                     s_set_sel,
    output dispatch_pkg::tag_t                      s_set_tag,
    output logic                                    m_set_en,
    output dispatch_pkg::mreg_t                     m_set_sel,
    output dispatch_pkg::tag_t                      m_set_tag,
    output logic                                    s_clr_en,
    output dispatch_pkg::sreg_t                     s_clr_sel,
    output logic                                    m_clr_en,
    output dispatch_pkg::mreg_t                     m_clr_sel,
    // fetch back-pressure and issue
    output logic                                    stall,
    output logic                                    issue_s_en,
    output dispatch_pkg::issue_s_t                  issue_s,
    output logic                                    issue_m_en,
    output dispatch_pkg::issue_m_t                  issue_m,
    output logic                                    issue_g_en,
    output dispatch_pkg::issue_g_t                  issue_g,
    output dispatch_pkg::dispatch_t                 out
);

    logic                    fu_hazard;
    logic                    waw;
    logic                    hazard;
    logic                    flush_v;
    logic                    accept;
    dispatch_pkg::dispatch_t new_word;
    dispatch_pkg::dispatch_t out_next;

    // structural hazard from the busy bit of the selected unit
    always_comb begin
        fu_hazard = 1'b0;
        case (decode.fu_type)
            dispatch_pkg::FU_S_T: begin
                case (decode.fu_s)
                    dispatch_pkg::FU_S_ALU:    fu_hazard = fu_busy.alu;
                    dispatch_pkg::FU_S_LD_ST:  fu_hazard = fu_busy.ldst;
                    dispatch_pkg::FU_S_BRANCH: fu_hazard = fu_busy.branch;
                    default:                   fu_hazard = 1'b0;
                endcase
            end
            dispatch_pkg::FU_M_T: fu_hazard = fu_busy.m_ldst;
            dispatch_pkg::FU_G_T: fu_hazard = fu_busy.gemm;
            default:              fu_hazard = 1'b0;
        endcase
    end

    // matrix destination takes precedence, decoder never sets both
    assign waw = decode.m_reg_write ? m_status[decode.m_rd].busy :
                 decode.s_reg_write ? s_status[decode.s_rd].busy : 1'b0;

    assign hazard  = fu_hazard | waw;
    assign stall   = instr_valid & hazard;
    assign flush_v = flush & instr_valid;
    assign accept  = instr_valid & ~hazard & ~flush & ~freeze;

    // destination goes pending at the next edge
    assign s_set_en  = accept & decode.s_reg_write;
    assign s_set_sel = decode.s_rd;
    assign s_set_tag = (decode.s_mem_type == dispatch_pkg::MEM_LOAD) ? `TAG_LD : `TAG_ALU;
    assign m_set_en  = accept & decode.m_reg_write;
    assign m_set_sel = decode.m_rd;
    assign m_set_tag = (decode.m_mem_type == dispatch_pkg::MEM_LOAD) ? `TAG_LD : `TAG_ALU;

    assign s_clr_en  = wb.s_rw_en;
    assign s_clr_sel = wb.s_rw;
    assign m_clr_en  = wb.m_rw_en;
    assign m_clr_sel = wb.m_rw;

    assign issue_s_en = accept & (decode.fu_type == dispatch_pkg::FU_S_T);
    assign issue_m_en = accept & (decode.fu_type == dispatch_pkg::FU_M_T);
    assign issue_g_en = accept & (decode.fu_type == dispatch_pkg::FU_G_T);

    always_comb begin
        issue_s.fu_s = decode.fu_s;
        issue_s.rd   = decode.s_rd;
        issue_s.rs1  = decode.s_rs1;
        issue_s.rs2  = decode.s_rs2;
        issue_s.imm  = decode.imm;
        issue_s.t1   = s_status[decode.s_rs1].tag;
        issue_s.t2   = s_status[decode.s_rs2].tag;

        issue_m.rd   = decode.m_rd;
        issue_m.rs1  = decode.s_rs1;    // base and stride are scalar
        issue_m.rs2  = decode.s_rs2;
        issue_m.imm  = decode.imm;
        issue_m.t1   = s_status[decode.s_rs1].tag;
        issue_m.t2   = s_status[decode.s_rs2].tag;

        issue_g.rd   = decode.m_rd;
        issue_g.ms1  = decode.m_rs1;
        issue_g.ms2  = decode.m_rs2;
        issue_g.ms3  = decode.m_rs3;
        issue_g.t1   = m_status[decode.m_rs1].tag;
        issue_g.t2   = m_status[decode.m_rs2].tag;
        issue_g.t3   = m_status[decode.m_rs3].tag;
    end

    // execute and writeback control word
    always_comb begin
        new_word.fu_s        = decode.fu_s;
        new_word.fu_m        = decode.fu_m;
        new_word.alu_op      = decode.alu_op;
        new_word.branch_op   = decode.branch_op;
        new_word.imm         = decode.imm;
        new_word.s_mem_type  = decode.s_mem_type;
        new_word.m_mem_type  = decode.m_mem_type;
        new_word.wb.s_rw_en  = decode.s_reg_write;
        new_word.wb.s_rw     = decode.s_rd;
        new_word.wb.m_rw_en  = decode.m_reg_write;
        new_word.wb.m_rw     = decode.m_rd;
    end

    always_comb begin
        if (flush_v)
            out_next = '0;
        else if (freeze || !instr_valid || hazard)
            out_next = out;     // hold
        else
            out_next = new_word;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            out <= '0;
        end else begin
            out <= out_next;
        end
    end

endmodule

// ==== dispatch_top.sv ====
`include "dispatch_defs.svh"

module dispatch_top (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    instr_valid,
    input  dispatch_pkg::word_t     instr,
    input  logic                    flush,
    input  logic                    freeze,
    input  dispatch_pkg::wb_t       wb,
    input  dispatch_pkg::fu_done_t  fu_done,
    output logic                    stall,
    output logic                    issue_s_en,
    output dispatch_pkg::issue_s_t  issue_s,
    output logic                    issue_m_en,
    output dispatch_pkg::issue_m_t  issue_m,
    output logic                    issue_g_en,
    output dispatch_pkg::issue_g_t  issue_g,
    output dispatch_pkg::dispatch_t out
);

    dispatch_pkg::decode_t                  decode;
    dispatch_pkg::rst_entry_t [`S_REGS-1:0] s_status;
    dispatch_pkg::rst_entry_t [`M_REGS-1:0] m_status;
    dispatch_pkg::fu_done_t                 fu_busy;

    logic                s_set_en;
    dispatch_pkg::sreg_t s_set_sel;
    dispatch_pkg::tag_t  s_set_tag;
    logic                m_set_en;
    dispatch_pkg::mreg_t m_set_sel;
    dispatch_pkg::tag_t  m_set_tag;
    logic                s_clr_en;
    dispatch_pkg::sreg_t s_clr_sel;
    logic                m_clr_en;
    dispatch_pkg::mreg_t m_clr_sel;

    instr_decoder instr_decoder_i (.instr(instr), .decode(decode));

    reg_status_table #(.NREGS(`S_REGS)) s_rst_i (
        .CLK(CLK), .nRST(nRST),
        .set_en(s_set_en), .set_sel(s_set_sel), .set_tag(s_set_tag),
        .clr_en(s_clr_en), .clr_sel(s_clr_sel),
        .status(s_status)
    );

    reg_status_table #(.NREGS(`M_REGS)) m_rst_i (
        .CLK(CLK), .nRST(nRST),
        .set_en(m_set_en), .set_sel(m_set_sel), .set_tag(m_set_tag),
        .clr_en(m_clr_en), .clr_sel(m_clr_sel),
        .status(m_status)
    );

    fu_status_table fu_status_table_i (
        .CLK(CLK), .nRST(nRST),
        .issue_s_en(issue_s_en), .issue_s_fu(issue_s.fu_s),
        .issue_m_en(issue_m_en), .issue_g_en(issue_g_en),
        .fu_done(fu_done), .busy(fu_busy)
    );

    dispatch_stage dispatch_stage_i (
        .CLK(CLK), .nRST(nRST),
        .instr_valid(instr_valid), .flush(flush), .freeze(freeze),
        .decode(decode), .wb(wb),
        .s_status(s_status), .m_status(m_status), .fu_busy(fu_busy),
        .s_set_en(s_set_en), .s_set_sel(s_set_sel), .s_set_tag(s_set_tag),
        .m_set_en(m_set_en), .m_set_sel(m_set_sel), .m_set_tag(m_set_tag),
        .s_clr_en(s_clr_en), .s_clr_sel(s_clr_sel),
        .m_clr_en(m_clr_en), .m_clr_sel(m_clr_sel),
        .stall(stall),
        .issue_s_en(issue_s_en), .issue_s(issue_s),
        .issue_m_en(issue_m_en), .issue_m(issue_m),
        .issue_g_en(issue_g_en), .issue_g(issue_g),
        .out(out)
    );

endmodule

// ==== dispatch_checker.sv ====
`include "dispatch_defs.svh"

module dispatch_checker (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    instr_valid,
    input  dispatch_pkg::word_t     instr,
    input  logic                    flush,
    input  logic                    freeze,
    input  dispatch_pkg::wb_t       wb,
    input  dispatch_pkg::fu_done_t  fu_done,
    input  logic                    stall,
    input  logic                    issue_s_en,
    input  dispatch_pkg::issue_s_t  issue_s,
    input  logic                    issue_m_en,
    input  dispatch_pkg::issue_m_t  issue_m,
    input  logic                    issue_g_en,
    input  dispatch_pkg::issue_g_t  issue_g,
    input  dispatch_pkg::dispatch_t out,
    output logic [`S_REGS-1:0]      s_busy,     // model state, read by the strobe picker
    output logic [`M_REGS-1:0]      m_busy,
    output dispatch_pkg::fu_done_t  u_busy,
    output int                      checks,
    output int                      mismatches
);

    dispatch_pkg::tag_t      s_tag [`S_REGS];
    dispatch_pkg::tag_t      m_tag [`M_REGS];
    dispatch_pkg::dispatch_t exp_out;

    function automatic dispatch_pkg::decode_t model_decode(input dispatch_pkg::word_t w);
        dispatch_pkg::decode_t d;
        logic [6:0]            op;
        logic [2:0]            f3;

        op = w[6:0];
        f3 = w[14:12];
        d = '0;
        d.s_rd  = w[11:7];
        d.s_rs1 = w[19:15];
        d.s_rs2 = w[24:20];
        d.m_rd  = w[31:28];
        d.m_rs1 = w[27:24];
        d.m_rs2 = w[23:20];
        d.m_rs3 = w[19:16];
        if (op inside {`OP_ALU, `OP_ALU_IMM, `OP_LOAD, `OP_STORE, `OP_BRANCH})
            d.fu_type = dispatch_pkg::FU_S_T;
        else if (op inside {`OP_M_LOAD, `OP_M_STORE})
            d.fu_type = dispatch_pkg::FU_M_T;
        else if (op == `OP_GEMM)
            d.fu_type = dispatch_pkg::FU_G_T;
        if (op inside {`OP_LOAD, `OP_STORE})
            d.fu_s = dispatch_pkg::FU_S_LD_ST;
        else if (op == `OP_BRANCH)
            d.fu_s = dispatch_pkg::FU_S_BRANCH;
        if (op == `OP_GEMM)
            d.fu_m = dispatch_pkg::FU_M_GEMM;
        case (op)
            `OP_ALU_IMM, `OP_LOAD:   d.imm = w[31:20];
            `OP_STORE:               d.imm = {w[31:25], w[11:7]};
            `OP_BRANCH:              d.imm = {w[31], w[7], w[30:25], w[11:8]};
            `OP_M_LOAD, `OP_M_STORE: d.imm = {{4{w[14]}}, w[14:7]};
            default:                 d.imm = '0;
        endcase
        if (op == `OP_ALU)
            d.alu_op = {w[30], f3};
        else if (op == `OP_ALU_IMM)
            d.alu_op = {w[30] && f3 == 3'b101, f3};     // only srai keeps bit 30
        if (op == `OP_BRANCH)
            d.branch_op = f3;
        if (op == `OP_LOAD)
            d.s_mem_type = dispatch_pkg::MEM_LOAD;
        else if (op == `OP_STORE)
            d.s_mem_type = dispatch_pkg::MEM_STORE;
        if (op == `OP_M_LOAD)
            d.m_mem_type = dispatch_pkg::MEM_LOAD;
        else if (op == `OP_M_STORE)
            d.m_mem_type = dispatch_pkg::MEM_STORE;
        d.s_reg_write = (op inside {`OP_ALU, `OP_ALU_IMM, `OP_LOAD}) && w[11:7] != 5'd0;
        d.m_reg_write = op inside {`OP_M_LOAD, `OP_GEMM};
        return d;
    endfunction

    task automatic expect_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Error: time %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // compare this cycle against the model, then advance the model one edge
    task automatic step_model();
        dispatch_pkg::decode_t   d;
        dispatch_pkg::issue_s_t  es;
        dispatch_pkg::issue_m_t  em;
        dispatch_pkg::issue_g_t  eg;
        dispatch_pkg::dispatch_t nw;
        logic                    unit_busy;
        logic                    hazard;
        logic                    acc;

        d = model_decode(instr);
        case (d.fu_type)
            dispatch_pkg::FU_S_T:
                unit_busy = (d.fu_s == dispatch_pkg::FU_S_ALU)   ? u_busy.alu  :
                            (d.fu_s == dispatch_pkg::FU_S_LD_ST) ? u_busy.ldst : u_busy.branch;
            dispatch_pkg::FU_M_T: unit_busy = u_busy.m_ldst;
            dispatch_pkg::FU_G_T: unit_busy = u_busy.gemm;
            default:              unit_busy = 1'b0;
        endcase
        hazard = unit_busy | (d.m_reg_write & m_busy[d.m_rd]) | (d.s_reg_write & s_busy[d.s_rd]);
        acc = instr_valid & ~hazard & ~flush & ~freeze;
        es = '{d.fu_s, d.s_rd, d.s_rs1, d.s_rs2, d.imm, s_tag[d.s_rs1], s_tag[d.s_rs2]};
        em = '{d.m_rd, d.s_rs1, d.s_rs2, d.imm, s_tag[d.s_rs1], s_tag[d.s_rs2]};
        eg = '{d.m_rd, d.m_rs1, d.m_rs2, d.m_rs3,
               m_tag[d.m_rs1], m_tag[d.m_rs2], m_tag[d.m_rs3]};
        nw = '{d.fu_s, d.fu_m, d.alu_op, d.branch_op, d.imm, d.s_mem_type, d.m_mem_type,
               '{d.s_reg_write, d.s_rd, d.m_reg_write, d.m_rd}};

        expect_eq("stall", 64'(stall), 64'(instr_valid & hazard));
        expect_eq("issue_s_en", 64'(issue_s_en), 64'(acc && d.fu_type == dispatch_pkg::FU_S_T));
        expect_eq("issue_m_en", 64'(issue_m_en), 64'(acc && d.fu_type == dispatch_pkg::FU_M_T));
        expect_eq("issue_g_en", 64'(issue_g_en), 64'(acc && d.fu_type == dispatch_pkg::FU_G_T));
        if (acc && d.fu_type == dispatch_pkg::FU_S_T)
            expect_eq("issue_s", 64'(issue_s), 64'(es));
        if (acc && d.fu_type == dispatch_pkg::FU_M_T)
            expect_eq("issue_m", 64'(issue_m), 64'(em));
        if (acc && d.fu_type == dispatch_pkg::FU_G_T)
            expect_eq("issue_g", 64'(issue_g), 64'(eg));
        expect_eq("out", 64'(out), 64'(exp_out));

        if (flush && instr_valid)
            exp_out = '0;
        else if (acc)
            exp_out = nw;

        // writeback and completion free their entries at the edge
        if (wb.s_rw_en) begin
            s_busy[wb.s_rw] = 1'b0;
            s_tag[wb.s_rw]  = '0;
        end
        if (wb.m_rw_en) begin
            m_busy[wb.m_rw] = 1'b0;
            m_tag[wb.m_rw]  = '0;
        end
        u_busy = u_busy & ~fu_done;

        if (acc && d.s_reg_write) begin
            s_busy[d.s_rd] = 1'b1;
            s_tag[d.s_rd]  = (d.s_mem_type == dispatch_pkg::MEM_LOAD) ? `TAG_LD : `TAG_ALU;
        end
        if (acc && d.m_reg_write) begin
            m_busy[d.m_rd] = 1'b1;
            m_tag[d.m_rd]  = (d.m_mem_type == dispatch_pkg::MEM_LOAD) ? `TAG_LD : `TAG_ALU;
        end
        u_busy.alu    |= acc && d.fu_type == dispatch_pkg::FU_S_T && d.fu_s == dispatch_pkg::FU_S_ALU;
        u_busy.ldst   |= acc && d.fu_type == dispatch_pkg::FU_S_T && d.fu_s == dispatch_pkg::FU_S_LD_ST;
        u_busy.branch |= acc && d.fu_type == dispatch_pkg::FU_S_T && d.fu_s == dispatch_pkg::FU_S_BRANCH;
        u_busy.m_ldst |= acc && d.fu_type == dispatch_pkg::FU_M_T;
        u_busy.gemm   |= acc && d.fu_type == dispatch_pkg::FU_G_T;
    endtask

    // inputs change on the rising edge, so the falling edge sees everything settled
    always @(negedge CLK) begin
        if (!nRST) begin
            s_busy     = '0;
            m_busy     = '0;
            u_busy     = '0;
            exp_out    = '0;
            checks     = 0;
            mismatches = 0;
            for (int i = 0; i < `S_REGS; i++)
                s_tag[i] = '0;
            for (int i = 0; i < `M_REGS; i++)
                m_tag[i] = '0;
        end else begin
            step_model();
        end
    end

endmodule

// ==== dispatch_assert.sv ====
module dispatch_assert (
    input logic                    CLK,
    input logic                    nRST,
    input logic                    stall,
    input logic                    flush,
    input logic                    freeze,
    input logic                    issue_s_en,
    input logic                    issue_m_en,
    input logic                    issue_g_en,
    input dispatch_pkg::dispatch_t out
);

    one_issue: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0({issue_s_en, issue_m_en, issue_g_en}))
        else $error("more than one issue enable high");

    // back-pressure and pipeline control both block the issue
    no_blocked_issue: assert property (@(posedge CLK) disable iff (!nRST)
        (stall || flush || freeze) |-> !(issue_s_en || issue_m_en || issue_g_en))
        else $error("issue while stall, flush or freeze high");

    // a stalled or frozen cycle leaves the pipeline register as it was
    hold_out: assert property (@(posedge CLK) disable iff (!nRST)
        ((stall || freeze) && !flush) |=> $stable(out))
        else $error("out changed during stall or freeze");

    out_clear_at_release: assert property (@(posedge CLK) $rose(nRST) |-> out == '0)
        else $error("out not zero after reset release");

endmodule

bind dispatch_stage dispatch_assert dispatch_assert_i (
    .CLK(CLK), .nRST(nRST),
    .stall(stall), .flush(flush), .freeze(freeze),
    .issue_s_en(issue_s_en), .issue_m_en(issue_m_en), .issue_g_en(issue_g_en),
    .out(out)
);

// ==== tb_dispatch.sv ====
`include "dispatch_defs.svh"

module tb_dispatch;

    localparam int N_OPS     = 2000;
    localparam int STALL_MAX = 200;     // cycles an instruction may wait on a hazard

    logic                    CLK;
    logic                    nRST;
    logic                    instr_valid;
    dispatch_pkg::word_t     instr;
    logic                    flush;
    logic                    freeze;
    dispatch_pkg::wb_t       wb = '0;
    dispatch_pkg::fu_done_t  fu_done = '0;
    logic                    stall;
    logic                    issue_s_en;
    dispatch_pkg::issue_s_t  issue_s;
    logic                    issue_m_en;
    dispatch_pkg::issue_m_t  issue_m;
    logic                    issue_g_en;
    dispatch_pkg::issue_g_t  issue_g;
    dispatch_pkg::dispatch_t out;
    logic [`S_REGS-1:0]      s_busy;    // model view of the tables
    logic [`M_REGS-1:0]      m_busy;
    dispatch_pkg::fu_done_t  u_busy;
    int                      checks;
    int                      mismatches;
    int                      timeouts;

    dispatch_top dispatch_top_i (.*);

    dispatch_checker checker_i (.*);

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // register fields narrowed per format so that hazards come up often
    function automatic dispatch_pkg::word_t rand_instr();
        logic [31:0] r;
        logic [31:0] w;

        r = $urandom;
        w = $urandom;
        case (r[2:0])
            3'd0:    w[6:0] = `OP_ALU;
            3'd1:    w[6:0] = `OP_ALU_IMM;
            3'd2:    w[6:0] = `OP_LOAD;
            3'd3:    w[6:0] = `OP_STORE;
            3'd4:    w[6:0] = `OP_BRANCH;
            3'd5:    w[6:0] = `OP_M_LOAD;
            3'd6:    w[6:0] = `OP_M_STORE;
            default: w[6:0] = `OP_GEMM;
        endcase
        if (w[6:0] == `OP_GEMM)
            w = w & 32'h3333_ffff;
        else if (w[6:0] == `OP_M_LOAD || w[6:0] == `OP_M_STORE)
            w = w & 32'h3e31_ffff;
        else
            w = w & 32'hfe31_f1ff;
        return w;
    endfunction

    task automatic drive_cycle(input logic valid, input logic fl, input logic fr);
        @(posedge CLK);
        instr_valid <= valid;
        instr       <= rand_instr();
        flush       <= fl;
        freeze      <= fr;
    endtask

    // hold the instruction until stall drops
    task automatic send_instr(input dispatch_pkg::word_t w);
        int waited;

        @(posedge CLK);
        instr_valid <= 1'b1;
        instr       <= w;
        flush       <= 1'b0;
        freeze      <= 1'b0;
        @(negedge CLK);
        waited = 0;
        while (stall && waited < STALL_MAX) begin
            @(negedge CLK);
            waited++;
        end
        if (stall) begin
            $display("Timeout: instruction %h still stalled after %0d cycles", w, STALL_MAX);
            timeouts++;
        end
    endtask

    task automatic drive_strobes();
        int                     s_q[$];
        int                     m_q[$];
        int                     i;
        logic [31:0]            r;
        dispatch_pkg::wb_t      wb_n;
        dispatch_pkg::fu_done_t done_n;

        r = $urandom;
        wb_n = '0;
        done_n = '0;
        for (i = 1; i < `S_REGS; i++)
            if (s_busy[i])
                s_q.push_back(i);
        for (i = 0; i < `M_REGS; i++)
            if (m_busy[i])
                m_q.push_back(i);
        if (r[0] && s_q.size() > 0) begin
            wb_n.s_rw_en = 1'b1;
            wb_n.s_rw    = dispatch_pkg::sreg_t'(s_q[$urandom_range(s_q.size() - 1, 0)]);
        end
        if (r[1] && m_q.size() > 0) begin
            wb_n.m_rw_en = 1'b1;
            wb_n.m_rw    = dispatch_pkg::mreg_t'(m_q[$urandom_range(m_q.size() - 1, 0)]);
        end
        done_n.alu    = u_busy.alu    & (r[5:4] == 2'd0);
        done_n.ldst   = u_busy.ldst   & (r[7:6] == 2'd0);
        done_n.branch = u_busy.branch & (r[9:8] == 2'd0);
        done_n.m_ldst = u_busy.m_ldst & (r[11:10] == 2'd0);
        done_n.gemm   = u_busy.gemm   & (r[13:12] == 2'd0);
        wb      <= wb_n;
        fu_done <= done_n;
    endtask

    always @(posedge CLK) begin
        if (!nRST) begin
            wb      <= '0;
            fu_done <= '0;
        end else begin
            drive_strobes();
        end
    end

    initial begin
        logic [31:0] r;
        int          n;

        void'($urandom(97));
        nRST        = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        flush       = 1'b0;
        freeze      = 1'b0;
        timeouts    = 0;
        repeat (10) @(posedge CLK);
        nRST <= 1'b1;

        for (n = 0; n < N_OPS; n++) begin
            r = $urandom;
            if (r[3:0] < 4'd10)
                send_instr(rand_instr());
            else if (r[3:0] < 4'd12)
                drive_cycle(1'b0, 1'b0, 1'b0);
            else if (r[3:0] < 4'd14)
                drive_cycle(1'b1, 1'b1, 1'b0);     // flush
            else
                drive_cycle(1'b1, 1'b0, 1'b1);     // freeze
        end
        drive_cycle(1'b0, 1'b0, 1'b0);
        repeat (3) @(negedge CLK);

        $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+.
dispatch_pkg.sv
instr_decoder.sv
reg_status_table.sv
fu_status_table.sv
dispatch_stage.sv
dispatch_top.sv
dispatch_checker.sv
dispatch_assert.sv
tb_dispatch.sv

// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_dispatch -f build.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_dispatch > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
exit 0
